// File: source/axi_params.svh
`ifndef AXI_PARAMS_SVH
`define AXI_PARAMS_SVH

// Master-side and slave-side ID widths
`define AXI_ID_BITS 4
`define AXI_IDS_BITS 8

`define AXI_ADDR_BITS 32
`define AXI_DATA_BITS 32

// Burst control fields
`define AXI_LEN_BITS 4
`define AXI_SIZE_BITS 3

// Address bit that picks slave 1 when set
`define AXI_SLAVE_SEL_BIT 16

`endif

// File: source/axi_read_pkg.sv
`include "axi_params.svh"

package axi_read_pkg;

	// Read request as issued by a master
	typedef struct packed {
		logic [`AXI_ID_BITS-1:0] id;
		logic [`AXI_ADDR_BITS-1:0] addr;
		logic [`AXI_LEN_BITS-1:0] len;
		logic [`AXI_SIZE_BITS-1:0] size;
		logic [1:0] burst;
	} ar_m_t;

	// Request on the slave side, master ID in the top nibble, master index in bit 0
	typedef struct packed {
		logic [`AXI_IDS_BITS-1:0] id;
		logic [`AXI_ADDR_BITS-1:0] addr;
		logic [`AXI_LEN_BITS-1:0] len;
		logic [`AXI_SIZE_BITS-1:0] size;
		logic [1:0] burst;
	} ar_s_t;

	// Read beat from a slave
	typedef struct packed {
		logic [`AXI_IDS_BITS-1:0] id;
		logic [`AXI_DATA_BITS-1:0] data;
		logic [1:0] resp;
		logic last;
	} r_s_t;

	// Read beat towards a master
	typedef struct packed {
		logic [`AXI_ID_BITS-1:0] id;
		logic [`AXI_DATA_BITS-1:0] data;
		logic [1:0] resp;
		logic last;
	} r_m_t;

endpackage

// File: source/axi_hold_stage.sv
`timescale 1ns/1ps
`include "axi_params.svh"

module axi_hold_stage import axi_read_pkg::*; #(
	parameter type payload_t = ar_m_t
) (
	input logic ACLK,
	input logic ARESETn,
	input payload_t in_data,
	input logic in_valid,
	output logic in_ready,
	output payload_t out_data,
	output logic out_valid,
	input logic out_ready
);

	logic full;
	payload_t data_q;

	// Room when empty or when the held item leaves this cycle
	assign in_ready = !full || out_ready;

	assign out_valid = full;
	assign out_data = data_q;

	always_ff @(posedge ACLK or negedge ARESETn) begin
		if (!ARESETn) begin
			full <= 1'b0;
		end else if (in_ready) begin
			full <= in_valid;
		end
	end

	// Payload register, loaded on every accepted item
	always_ff @(posedge ACLK) begin
		if (in_valid && in_ready) begin
			data_q <= in_data;
		end
	end

	// A stalled item must not change before it is taken
	property p_hold_stable;
		@(posedge ACLK) disable iff (!ARESETn)
		out_valid && !out_ready |=> out_valid && $stable(out_data);
	endproperty

	a_hold_stable: assert property (p_hold_stable)
		else $error("hold stage output changed while stalled");

endmodule

// File: source/ar_arbiter.sv
`timescale 1ns/1ps
`include "axi_params.svh"

module ar_arbiter import axi_read_pkg::*; (
	input logic ACLK,
	input logic ARESETn,
	input ar_m_t m0_ar,
	input ar_m_t m1_ar,
	input logic m0_valid,
	input logic m1_valid,
	output logic m0_ready,
	output logic m1_ready,
	output ar_s_t s_ar,
	output logic s0_arvalid,
	output logic s1_arvalid,
	input logic s0_arready,
	input logic s1_arready,
	output logic r_slave,
	input logic r_done
);

	logic busy;
	logic locked;
	logic lock_m;
	logic grant;
	logic req_valid;
	logic slave;
	logic slave_ready;
	logic handshake;
	ar_m_t sel_ar;

	// M0 wins a tie unless M1 already holds the lock
	assign grant = locked ? lock_m : !m0_valid;
	assign sel_ar = grant ? m1_ar : m0_ar;
	assign req_valid = !busy && (grant ? m1_valid : m0_valid);

	// Slave decode from the select bit
	assign slave = sel_ar.addr[`AXI_SLAVE_SEL_BIT];

	always_comb begin
		s_ar.id = {sel_ar.id, {(`AXI_IDS_BITS-`AXI_ID_BITS-1){1'b0}}, grant};
		s_ar.addr = sel_ar.addr;
		s_ar.len = sel_ar.len;
		s_ar.size = sel_ar.size;
		s_ar.burst = sel_ar.burst;
	end

	assign s0_arvalid = req_valid && !slave;
	assign s1_arvalid = req_valid && slave;

	assign slave_ready = slave ? s1_arready : s0_arready;
	assign handshake = req_valid && slave_ready;

	// Ready goes back only to the granted master
	assign m0_ready = !busy && !grant && slave_ready;
	assign m1_ready = !busy && grant && slave_ready;

	// Lock holds the grant while the chosen slave stalls
	always_ff @(posedge ACLK or negedge ARESETn) begin
		if (!ARESETn) begin
			locked <= 1'b0;
			lock_m <= 1'b0;
		end else if (handshake) begin
			locked <= 1'b0;
		end else if (req_valid && !locked) begin
			locked <= 1'b1;
			lock_m <= grant;
		end
	end

	// Burst tracking until the router reports the last beat
	always_ff @(posedge ACLK or negedge ARESETn) begin
		if (!ARESETn) begin
			busy <= 1'b0;
			r_slave <= 1'b0;
		end else if (handshake) begin
			busy <= 1'b1;
			r_slave <= slave;
		end else if (r_done) begin
			busy <= 1'b0;
		end
	end

	// Burst end only while a burst is open
	a_done_busy: assert property (@(posedge ACLK) disable iff (!ARESETn) r_done |-> busy)
		else $error("r_done seen with no open burst");

	a_one_slave: assert property (
		@(posedge ACLK) disable iff (!ARESETn) $onehot0({s0_arvalid, s1_arvalid})
	) else $error("both slave ARVALIDs high");

endmodule

// File: source/r_router.sv
`timescale 1ns/1ps
`include "axi_params.svh"

module r_router import axi_read_pkg::*; (
	input r_s_t s0_r,
	input r_s_t s1_r,
	input logic s0_valid,
	input logic s1_valid,
	output logic s0_ready,
	output logic s1_ready,
	output r_m_t m_r,
	output logic m0_rvalid,
	output logic m1_rvalid,
	input logic m0_rready,
	input logic m1_rready,
	input logic r_slave,
	output logic r_done
);

	r_s_t sel_r;
	logic sel_valid;
	logic dest;
	logic dest_ready;

	// Only the slave of the open burst is looked at
	assign sel_r = r_slave ? s1_r : s0_r;
	assign sel_valid = r_slave ? s1_valid : s0_valid;

	// Master index sits in ID bit 0
	assign dest = sel_r.id[0];

	always_comb begin
		m_r.id = sel_r.id[`AXI_IDS_BITS-1 -: `AXI_ID_BITS];
		m_r.data = sel_r.data;
		m_r.resp = sel_r.resp;
		m_r.last = sel_r.last;
	end

	assign m0_rvalid = sel_valid && !dest;
	assign m1_rvalid = sel_valid && dest;

	assign dest_ready = dest ? m1_rready : m0_rready;

	// Back-pressure from the addressed master only
	assign s0_ready = !r_slave && dest_ready;
	assign s1_ready = r_slave && dest_ready;

	// Last beat handed over
	assign r_done = sel_valid && dest_ready && sel_r.last;

	always_comb begin
		a_one_master: assert final ($onehot0({m0_rvalid, m1_rvalid}))
			else $error("both master RVALIDs high");
	end

endmodule

// File: source/axi_read_xbar.sv
`timescale 1ns/1ps
`include "axi_params.svh"

module axi_read_xbar import axi_read_pkg::*; (
	input logic ACLK,
	input logic ARESETn,

	// Master 0
	input ar_m_t m0_ar,
	input logic m0_arvalid,
	output logic m0_arready,
	output logic m0_rvalid,
	input logic m0_rready,

	// Master 1
	input ar_m_t m1_ar,
	input logic m1_arvalid,
	output logic m1_arready,
	output logic m1_rvalid,
	input logic m1_rready,

	// Shared read beat to both masters
	output r_m_t m_r,

	// Shared request to both slaves
	output ar_s_t s_ar,
	output logic s0_arvalid,
	input logic s0_arready,
	output logic s1_arvalid,
	input logic s1_arready,

	// Slave read data
	input r_s_t s0_r,
	input logic s0_rvalid,
	output logic s0_rready,
	input r_s_t s1_r,
	input logic s1_rvalid,
	output logic s1_rready
);

	ar_m_t m0_ar_q;
	ar_m_t m1_ar_q;
	logic m0_ar_valid;
	logic m1_ar_valid;
	logic m0_ar_ready;
	logic m1_ar_ready;
	r_s_t s0_r_q;
	r_s_t s1_r_q;
	logic s0_r_valid;
	logic s1_r_valid;
	logic s0_r_ready;
	logic s1_r_ready;
	logic r_slave;
	logic r_done;

	// Request slices
	axi_hold_stage #(.payload_t(ar_m_t)) u_m0_ar_slice (
		.ACLK(ACLK), .ARESETn(ARESETn),
		.in_data(m0_ar), .in_valid(m0_arvalid), .in_ready(m0_arready),
		.out_data(m0_ar_q), .out_valid(m0_ar_valid), .out_ready(m0_ar_ready)
	);

	axi_hold_stage #(.payload_t(ar_m_t)) u_m1_ar_slice (
		.ACLK(ACLK), .ARESETn(ARESETn),
		.in_data(m1_ar), .in_valid(m1_arvalid), .in_ready(m1_arready),
		.out_data(m1_ar_q), .out_valid(m1_ar_valid), .out_ready(m1_ar_ready)
	);

	// Read data slices
	axi_hold_stage #(.payload_t(r_s_t)) u_s0_r_slice (
		.ACLK(ACLK), .ARESETn(ARESETn),
		.in_data(s0_r), .in_valid(s0_rvalid), .in_ready(s0_rready),
		.out_data(s0_r_q), .out_valid(s0_r_valid), .out_ready(s0_r_ready)
	);

	axi_hold_stage #(.payload_t(r_s_t)) u_s1_r_slice (
		.ACLK(ACLK), .ARESETn(ARESETn),
		.in_data(s1_r), .in_valid(s1_rvalid), .in_ready(s1_rready),
		.out_data(s1_r_q), .out_valid(s1_r_valid), .out_ready(s1_r_ready)
	);

	ar_arbiter u_arbiter (
		.ACLK(ACLK), .ARESETn(ARESETn),
		.m0_ar(m0_ar_q), .m1_ar(m1_ar_q),
		.m0_valid(m0_ar_valid), .m1_valid(m1_ar_valid),
		.m0_ready(m0_ar_ready), .m1_ready(m1_ar_ready),
		.s_ar(s_ar), .s0_arvalid(s0_arvalid), .s1_arvalid(s1_arvalid),
		.s0_arready(s0_arready), .s1_arready(s1_arready),
		.r_slave(r_slave), .r_done(r_done)
	);

	r_router u_router (
		.s0_r(s0_r_q), .s1_r(s1_r_q),
		.s0_valid(s0_r_valid), .s1_valid(s1_r_valid),
		.s0_ready(s0_r_ready), .s1_ready(s1_r_ready),
		.m_r(m_r), .m0_rvalid(m0_rvalid), .m1_rvalid(m1_rvalid),
		.m0_rready(m0_rready), .m1_rready(m1_rready),
		.r_slave(r_slave), .r_done(r_done)
	);

endmodule

// File: tests/tb_mem_slave.sv
`timescale 1ns/1ps
`include "axi_params.svh"

module tb_mem_slave import axi_read_pkg::*; #(
	parameter logic SLAVE_IDX = 1'b0
) (
	input logic ACLK,
	input logic ARESETn,
	input ar_s_t ar,
	input logic arvalid,
	output logic arready,
	output r_s_t r,
	output logic rvalid,
	input logic rready,
	output logic stuck
);

	localparam int RREADY_LIMIT = 1000;

	logic [31:0] rng_state;
	ar_s_t req;
	logic seen;
	int waited;

	function automatic logic [31:0] next_random();
		rng_state = rng_state ^ (rng_state << 13);
		rng_state = rng_state ^ (rng_state >> 17);
		rng_state = rng_state ^ (rng_state << 5);
		return rng_state;
	endfunction

	// Zero to three idle cycles
	task automatic idle_cycles();
		int n;
		n = int'(next_random() % 4);
		repeat (n) begin
			@(posedge ACLK);
			#1;
		end
	endtask

	initial begin
		// Seed 40, offset by the slave index so the two slaves stall differently
		rng_state = 32'd40 + 32'(SLAVE_IDX);
		arready = 1'b0;
		rvalid = 1'b0;
		r = '0;
		stuck = 1'b0;
		req = '0;
		while (ARESETn !== 1'b1) begin
			@(posedge ACLK);
			#1;
		end
		forever begin
			idle_cycles();
			arready = 1'b1;
			seen = 1'b0;
			// Idle state, waiting for the next request
			while (!seen) begin
				@(negedge ACLK);
				seen = arvalid;
				if (seen) begin
					req = ar;
				end
				@(posedge ACLK);
				#1;
			end
			arready = 1'b0;
			for (int k = 0; k <= int'(req.len); k++) begin
				idle_cycles();
				r.id = req.id;
				r.data = req.addr + 32'(k * 4);
				r.data[31] = r.data[31] | SLAVE_IDX;
				r.resp = 2'b00;
				r.last = (k == int'(req.len));
				rvalid = 1'b1;
				seen = 1'b0;
				waited = 0;
				while (!seen && waited < RREADY_LIMIT) begin
					@(negedge ACLK);
					seen = rready;
					@(posedge ACLK);
					#1;
					waited++;
				end
				rvalid = 1'b0;
				if (!seen) begin
					$display("Slave %0d gave up on a beat after %0d cycles without RREADY",
						SLAVE_IDX, waited);
					stuck = 1'b1;
				end
			end
		end
	end

endmodule

// File: tests/axi_read_xbar_tb.sv
`timescale 1ns/1ps
`include "axi_params.svh"

module axi_read_xbar_tb import axi_read_pkg::*; ();

	localparam int CLK_PERIOD = 40;
	localparam int TIMEOUT_CYCLES = 500;
	localparam int NUM_STIM = 12;

	// One read request per entry
	typedef struct packed {
		logic [3:0] test;
		logic master;
		logic [`AXI_ID_BITS-1:0] id;
		logic [`AXI_ADDR_BITS-1:0] addr;
		logic [`AXI_LEN_BITS-1:0] len;
		logic paired;
		logic stall;
	} stim_t;

	logic ACLK;
	logic ARESETn;
	ar_m_t m0_ar;
	ar_m_t m1_ar;
	logic m0_arvalid, m0_arready, m0_rvalid, m0_rready;
	logic m1_arvalid, m1_arready, m1_rvalid, m1_rready;
	r_m_t m_r;
	ar_s_t s_ar;
	logic s0_arvalid, s0_arready, s1_arvalid, s1_arready;
	r_s_t s0_r;
	r_s_t s1_r;
	logic s0_rvalid, s0_rready, s0_stuck;
	logic s1_rvalid, s1_rready, s1_stuck;

	stim_t stim [NUM_STIM];
	time first_beat_t [NUM_STIM];
	time last_beat_t [NUM_STIM];
	logic [31:0] rng_state;
	int errors;
	int tests_run;
	int tests_failed;

	axi_read_xbar u_dut (
		.ACLK(ACLK), .ARESETn(ARESETn),
		.m0_ar(m0_ar), .m0_arvalid(m0_arvalid), .m0_arready(m0_arready),
		.m0_rvalid(m0_rvalid), .m0_rready(m0_rready),
		.m1_ar(m1_ar), .m1_arvalid(m1_arvalid), .m1_arready(m1_arready),
		.m1_rvalid(m1_rvalid), .m1_rready(m1_rready),
		.m_r(m_r), .s_ar(s_ar),
		.s0_arvalid(s0_arvalid), .s0_arready(s0_arready),
		.s1_arvalid(s1_arvalid), .s1_arready(s1_arready),
		.s0_r(s0_r), .s0_rvalid(s0_rvalid), .s0_rready(s0_rready),
		.s1_r(s1_r), .s1_rvalid(s1_rvalid), .s1_rready(s1_rready)
	);

	tb_mem_slave #(.SLAVE_IDX(1'b0)) u_slave0 (
		.ACLK(ACLK), .ARESETn(ARESETn), .ar(s_ar), .arvalid(s0_arvalid),
		.arready(s0_arready), .r(s0_r), .rvalid(s0_rvalid), .rready(s0_rready),
		.stuck(s0_stuck)
	);

	tb_mem_slave #(.SLAVE_IDX(1'b1)) u_slave1 (
		.ACLK(ACLK), .ARESETn(ARESETn), .ar(s_ar), .arvalid(s1_arvalid),
		.arready(s1_arready), .r(s1_r), .rvalid(s1_rvalid), .rready(s1_rready),
		.stuck(s1_stuck)
	);

	initial begin
		ACLK = 1'b0;
		forever #(CLK_PERIOD / 2) ACLK = ~ACLK;
	end

	function automatic logic [31:0] next_random();
		rng_state = rng_state ^ (rng_state << 13);
		rng_state = rng_state ^ (rng_state >> 17);
		rng_state = rng_state ^ (rng_state << 5);
		return rng_state;
	endfunction

	task automatic expect_equal(input logic [31:0] got, input logic [31:0] exp, input string what);
		assert (got === exp) else begin
			$display("CHECK FAILED at %0t: %s is 0x%0h, expected 0x%0h", $time, what, got, exp);
			errors++;
		end
	endtask

	task automatic report_test(input int num, input int err_before);
		tests_run++;
		if (errors == err_before) begin
			$display("test %0d done, no errors", num);
		end else begin
			tests_failed++;
			$display("test %0d done, %0d errors", num, errors - err_before);
		end
	endtask

	task automatic drive_master(input logic master, input ar_m_t req, input logic valid,
		input logic ready);
		if (master) begin
			m1_ar = req;
			m1_arvalid = valid;
			m1_rready = ready;
		end else begin
			m0_ar = req;
			m0_arvalid = valid;
			m0_rready = ready;
		end
	endtask

	// Columns: test, master, id, address, len, paired with next entry, RREADY stalls
	task automatic fill_table();
		stim[0] = '{4'd2, 1'b0, 4'h3, 32'h0000_0100, 4'd0, 1'b0, 1'b0};
		stim[1] = '{4'd3, 1'b1, 4'h9, 32'h0001_0200, 4'd3, 1'b0, 1'b0};
		stim[2] = '{4'd4, 1'b0, 4'h5, 32'h0000_0400, 4'd3, 1'b1, 1'b0};
		stim[3] = '{4'd4, 1'b1, 4'ha, 32'h0001_0800, 4'd2, 1'b1, 1'b0};
		stim[4] = '{4'd5, 1'b0, 4'h1, 32'h0000_1000, 4'd7, 1'b0, 1'b1};
		stim[5] = '{4'd5, 1'b1, 4'h2, 32'h0000_2000, 4'd2, 1'b0, 1'b1};
		stim[6] = '{4'd5, 1'b0, 4'h4, 32'h0001_3000, 4'd5, 1'b0, 1'b1};
		stim[7] = '{4'd5, 1'b1, 4'h6, 32'h0001_4000, 4'd15, 1'b0, 1'b1};
		stim[8] = '{4'd5, 1'b0, 4'h7, 32'h0000_5000, 4'd1, 1'b0, 1'b0};
		stim[9] = '{4'd5, 1'b1, 4'hc, 32'h0001_5000, 4'd0, 1'b0, 1'b1};
		stim[10] = '{4'd5, 1'b0, 4'h8, 32'h0001_6000, 4'd3, 1'b1, 1'b1};
		stim[11] = '{4'd5, 1'b1, 4'hf, 32'h0000_7000, 4'd4, 1'b1, 1'b1};
	endtask

	// Issue one entry and collect its burst
	task automatic run_read(input int idx);
		stim_t s;
		ar_m_t req;
		logic done;
		logic ready;
		logic req_seen;
		logic slave_hs;
		logic [`AXI_IDS_BITS-1:0] exp_id;
		int waited;
		int beat;
		logic [31:0] exp_data;
		s = stim[idx];
		req.id = s.id;
		req.addr = s.addr;
		req.len = s.len;
		req.size = 3'd2;
		req.burst = 2'b01;
		// Slave-side ID: master ID on top, master index in bit 0, zeros between
		exp_id = '0;
		exp_id[`AXI_IDS_BITS-1 -: `AXI_ID_BITS] = s.id;
		exp_id[0] = s.master;
		drive_master(s.master, req, 1'b1, 1'b0);
		done = 1'b0;
		waited = 0;
		while (!done && waited < TIMEOUT_CYCLES) begin
			@(negedge ACLK);
			done = s.master ? m1_arready : m0_arready;
			@(posedge ACLK);
			#1;
			waited++;
		end
		drive_master(s.master, req, 1'b0, 1'b0);
		if (!done) begin
			$display("Timeout: the request of entry %0d was never accepted", idx);
			errors++;
			return;
		end
		beat = 0;
		waited = 0;
		req_seen = 1'b0;
		while (beat <= int'(s.len) && waited < TIMEOUT_CYCLES) begin
			// RREADY low one cycle in four when stalling
			ready = !s.stall || (next_random() % 4 != 0);
			drive_master(s.master, req, 1'b0, ready);
			@(negedge ACLK);
			// Request handshake on the slave named by the select bit
			slave_hs = s.addr[`AXI_SLAVE_SEL_BIT] ? (s1_arvalid && s1_arready)
				: (s0_arvalid && s0_arready);
			if (slave_hs && !req_seen) begin
				req_seen = 1'b1;
				expect_equal(32'(s_ar.id), 32'(exp_id), $sformatf("entry %0d slave id", idx));
				expect_equal(s_ar.addr, s.addr, $sformatf("entry %0d slave addr", idx));
				expect_equal(32'(s_ar.len), 32'(s.len), $sformatf("entry %0d slave len", idx));
				expect_equal(32'(s_ar.size), 32'(req.size),
					$sformatf("entry %0d slave size", idx));
				expect_equal(32'(s_ar.burst), 32'(req.burst),
					$sformatf("entry %0d slave burst", idx));
			end
			done = ready && (s.master ? m1_rvalid : m0_rvalid);
			if (done) begin
				exp_data = s.addr + 32'(beat * 4);
				exp_data[31] = exp_data[31] | s.addr[`AXI_SLAVE_SEL_BIT];
				expect_equal(32'(m_r.id), 32'(s.id), $sformatf("entry %0d beat %0d id", idx, beat));
				expect_equal(m_r.data, exp_data, $sformatf("entry %0d beat %0d data", idx, beat));
				expect_equal(32'(m_r.resp), 32'd0, $sformatf("entry %0d beat %0d resp", idx, beat));
				expect_equal(32'(m_r.last), 32'(beat == int'(s.len)),
					$sformatf("entry %0d beat %0d last", idx, beat));
				if (beat == 0) begin
					first_beat_t[idx] = $time;
				end
				last_beat_t[idx] = $time;
				beat++;
				waited = 0;
			end else begin
				waited++;
			end
			@(posedge ACLK);
			#1;
		end
		drive_master(s.master, req, 1'b0, 1'b0);
		if (!req_seen) begin
			$display("The request of entry %0d never reached slave %0d", idx,
				s.addr[`AXI_SLAVE_SEL_BIT]);
			errors++;
		end
		if (beat <= int'(s.len)) begin
			$display("Timeout: entry %0d received %0d of %0d beats", idx, beat, s.len + 1);
			errors++;
		end
	endtask

	initial begin
		int num;
		int idx;
		int err_before;
		int first;
		m0_ar = '0;
		m1_ar = '0;
		m0_arvalid = 1'b0;
		m1_arvalid = 1'b0;
		m0_rready = 1'b0;
		m1_rready = 1'b0;
		ARESETn = 1'b0;
		errors = 0;
		tests_run = 0;
		tests_failed = 0;
		rng_state = 32'd40;
		for (idx = 0; idx < NUM_STIM; idx++) begin
			first_beat_t[idx] = 0;
			last_beat_t[idx] = 0;
		end
		fill_table();
		repeat (10) @(posedge ACLK);
		#1;
		ARESETn = 1'b1;

		// Idle outputs straight after reset
		err_before = errors;
		@(negedge ACLK);
		expect_equal(32'(s0_arvalid), 32'd0, "s0_arvalid after reset");
		expect_equal(32'(s1_arvalid), 32'd0, "s1_arvalid after reset");
		expect_equal(32'(m0_rvalid), 32'd0, "m0_rvalid after reset");
		expect_equal(32'(m1_rvalid), 32'd0, "m1_rvalid after reset");
		expect_equal(32'(m0_arready), 32'd1, "m0_arready after reset");
		expect_equal(32'(m1_arready), 32'd1, "m1_arready after reset");
		@(posedge ACLK);
		#1;
		report_test(1, err_before);

		for (num = 2; num <= 5; num++) begin
			err_before = errors;
			idx = 0;
			while (idx < NUM_STIM) begin
				if (int'(stim[idx].test) != num) begin
					idx++;
				end else if (stim[idx].paired) begin
					// Same-cycle requests, M0 wins and its burst ends first
					fork
						run_read(idx);
						run_read(idx + 1);
					join
					first = stim[idx].master ? idx + 1 : idx;
					assert (last_beat_t[first] < first_beat_t[2 * idx + 1 - first]) else begin
						$display("CHECK FAILED at %0t: M1 beat of entry %0d before M0 finished",
							$time, 2 * idx + 1 - first);
						errors++;
					end
					idx += 2;
				end else begin
					run_read(idx);
					idx++;
				end
			end
			report_test(num, err_before);
		end

		if (s0_stuck || s1_stuck) begin
			$display("A slave model stopped waiting for RREADY on a beat");
			errors++;
		end
		$display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
		if (errors == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

// File: vlog.f
+incdir+source
source/axi_read_pkg.sv
source/axi_hold_stage.sv
source/ar_arbiter.sv
source/r_router.sv
source/axi_read_xbar.sv
tests/tb_mem_slave.sv
tests/axi_read_xbar_tb.sv

// File: Makefile
# Verilator simulation of the AXI read crossbar

VERILATOR ?= verilator
TOP ?= axi_read_xbar_tb
FILELIST ?= vlog.f
OBJ_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert --timescale 1ns/1ps

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "TEST PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
